//--- src.f
verilog/uart_line_pkg.sv
verilog/uart_reg_pkg.sv
verilog/uart_fifo.sv
verilog/uart_ser.sv
verilog/uart_des.sv
verilog/uart_regs.sv
verilog/uart_ctl.sv
verification/uart_ctl_tb.sv

//--- verification/uart_ctl_tb.sv
// UART controller testbench
// directed tests over the register bus and the serial line, loopback or line driver

module uart_ctl_tb;

    // inputs change this long after the rising edge
    localparam int drv_dly = 5;
    // wait limits, in cycles or polls
    localparam int bus_tmo  = 5000;
    localparam int poll_tmo = 5000;
    localparam int line_tmo = 1000;

    logic                           clk;
    logic                           rst;
    logic                           bus_vld;
    logic                           bus_wen;
    logic [uart_reg_pkg::adr_w-1:0] bus_adr;
    logic [uart_reg_pkg::reg_w-1:0] bus_wdt;
    logic                           bus_rdy;
    logic                           rsp_vld;
    logic [uart_reg_pkg::reg_w-1:0] rsp_rdt;
    logic                           txd;
    logic                           rxd;

    // line mux, loopback or driven by the line task
    logic                            loop_en;
    logic                            line_rxd;
    // bit period the line tasks assume
    logic [uart_line_pkg::div_w-1:0] div_now;
    logic [31:0]                     lfsr_q;
    // bytes in flight, oldest first
    logic [uart_line_pkg::dat_w-1:0] exp_q[$];
    // seen across status polls
    logic                            stall_seen;
    logic                            ovr_seen;
    logic                            ferr_seen;

    assign rxd = loop_en ? txd : line_rxd;

    uart_ctl uart_ctl_inst (
        .clk, .rst,
        .bus_vld, .bus_wen, .bus_adr, .bus_wdt, .bus_rdy,
        .rsp_vld, .rsp_rdt,
        .txd, .rxd
    );

    // period 40
    always #20 clk = ~clk;

    ////////////////////////////////////////
    // failure and compare
    ////////////////////////////////////////

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_reg(input logic [uart_reg_pkg::reg_w-1:0] act,
                             input logic [uart_reg_pkg::reg_w-1:0] exp,
                             input string name);
        if (act !== exp) begin
            $display("Fail %0t %s: got %h, expected %h", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("Fail %0t %s: got %b, expected %b", $time, name, act, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // random bytes
    ////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic rand_byte(output logic [uart_line_pkg::dat_w-1:0] b);
        for (int i = 0; i < uart_line_pkg::dat_w; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b[i]   = lfsr_q[0];
        end
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) @(posedge clk);
        #drv_dly;
    endtask

    ////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////

    // hold keeps bus_vld up for a back-to-back write
    task automatic bus_write(input uart_reg_pkg::reg_adr_t adr,
                             input logic [uart_reg_pkg::reg_w-1:0] wdt,
                             input logic hold);
        int unsigned n;
        n       = 0;
        bus_vld = 1'b1;
        bus_wen = 1'b1;
        bus_adr = adr;
        bus_wdt = wdt;
        // bus_rdy settles before the falling edge
        @(negedge clk);
        while (!bus_rdy) begin
            stall_seen = 1'b1;
            if (n == bus_tmo) begin
                $display("timeout: bus_rdy stayed low on a write");
                abort_run();
            end
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        #drv_dly;
        // writes get no response
        check_bit(rsp_vld, 1'b0, "rsp_vld");
        if (!hold) begin
            bus_vld = 1'b0;
        end
    endtask

    task automatic bus_read(input uart_reg_pkg::reg_adr_t adr,
                            output logic [uart_reg_pkg::reg_w-1:0] rdt);
        int unsigned n;
        n       = 0;
        bus_vld = 1'b1;
        bus_wen = 1'b0;
        bus_adr = adr;
        bus_wdt = '0;
        @(negedge clk);
        while (!bus_rdy) begin
            if (n == bus_tmo) begin
                $display("timeout: bus_rdy stayed low on a read");
                abort_run();
            end
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        #drv_dly;
        bus_vld = 1'b0;
        // response one cycle after acceptance, one cycle wide
        @(negedge clk);
        check_bit(rsp_vld, 1'b1, "rsp_vld");
        rdt = rsp_rdt;
        @(posedge clk);
        #drv_dly;
        check_bit(rsp_vld, 1'b0, "rsp_vld");
    endtask

    task automatic set_baud(input logic [uart_line_pkg::div_w-1:0] d);
        logic [uart_reg_pkg::reg_w-1:0] r;
        bus_write(uart_reg_pkg::reg_baud, uart_reg_pkg::reg_w'(d), 1'b0);
        bus_read(uart_reg_pkg::reg_baud, r);
        check_reg(r, uart_reg_pkg::reg_w'(d), "reg_baud");
        div_now = d;
    endtask

    // read reg_stat until a count field hits target, flags collected on the way
    task automatic poll_stat(input int unsigned lo, input int unsigned target,
                             input string what);
        logic [uart_reg_pkg::reg_w-1:0] st;
        int unsigned n;
        n = 0;
        do begin
            if (n == poll_tmo) begin
                $display("timeout: %s never reached %0d", what, target);
                abort_run();
            end
            n++;
            bus_read(uart_reg_pkg::reg_stat, st);
            ovr_seen  = ovr_seen | st[uart_reg_pkg::stat_ovr];
            ferr_seen = ferr_seen | st[uart_reg_pkg::stat_ferr];
        end while (st[lo +: uart_line_pkg::cnt_w] != uart_line_pkg::cnt_w'(target));
    endtask

    task automatic write_random(input int unsigned n, input logic hold);
        logic [uart_line_pkg::dat_w-1:0] b;
        for (int unsigned i = 0; i < n; i++) begin
            rand_byte(b);
            exp_q.push_back(b);
            bus_write(uart_reg_pkg::reg_data, uart_reg_pkg::reg_w'(b), hold && (i != n - 1));
        end
    endtask

    task automatic read_expect(input int unsigned n);
        logic [uart_reg_pkg::reg_w-1:0]  r;
        logic [uart_line_pkg::dat_w-1:0] e;
        for (int unsigned i = 0; i < n; i++) begin
            e = exp_q.pop_front();
            bus_read(uart_reg_pkg::reg_data, r);
            check_reg(r, uart_reg_pkg::reg_w'(e), "reg_data");
        end
    endtask

    ////////////////////////////////////////
    // line tasks
    ////////////////////////////////////////

    // stop = 0 gives a framing error
    task automatic line_send_frame(input logic [uart_line_pkg::dat_w-1:0] dat,
                                   input logic stop);
        logic [9:0] frm;
        frm = {stop, dat, 1'b0};
        for (int b = 0; b < 10; b++) begin
            line_rxd = frm[b];
            repeat (div_now) @(posedge clk);
            #drv_dly;
        end
        line_rxd = 1'b1;
    endtask

    // every cycle of a bit must match its mid-bit sample
    task automatic line_recv_frame(output logic [uart_line_pkg::dat_w-1:0] dat);
        int unsigned n;
        logic        v;
        logic        smp_q[$];
        n   = 0;
        dat = '0;
        @(negedge clk);
        while (txd !== 1'b0) begin
            if (n == line_tmo) begin
                $display("timeout: no start bit on txd");
                abort_run();
            end
            n++;
            @(negedge clk);
        end
        // start, 8 data, stop
        for (int b = 0; b < 10; b++) begin
            smp_q.delete();
            for (int c = 0; c < div_now; c++) begin
                if (b != 0 || c != 0) begin
                    @(negedge clk);
                end
                smp_q.push_back(txd);
            end
            v = smp_q[div_now / 2];
            if (b == 0) begin
                check_bit(v, 1'b0, "txd start");
            end else if (b == 9) begin
                check_bit(v, 1'b1, "txd stop");
            end else begin
                dat[b - 1] = v;
            end
            foreach (smp_q[c]) begin
                check_bit(smp_q[c], v, "txd bit level");
            end
        end
        @(posedge clk);
        #drv_dly;
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_reset();
        logic [uart_reg_pkg::reg_w-1:0] r;
        check_bit(txd, 1'b1, "txd");
        bus_read(uart_reg_pkg::reg_stat, r);
        check_reg(r, '0, "reg_stat");
        bus_read(uart_reg_pkg::reg_baud, r);
        check_reg(r, uart_reg_pkg::reg_w'(uart_line_pkg::div_rst), "reg_baud");
        // empty RX FIFO
        bus_read(uart_reg_pkg::reg_data, r);
        check_reg(r, '0, "reg_data");
    endtask

    task automatic test_framing();
        logic [uart_line_pkg::dat_w-1:0] b;
        logic [uart_line_pkg::dat_w-1:0] got;
        set_baud(4);
        rand_byte(b);
        bus_write(uart_reg_pkg::reg_data, uart_reg_pkg::reg_w'(b), 1'b0);
        line_recv_frame(got);
        check_reg(uart_reg_pkg::reg_w'(got), uart_reg_pkg::reg_w'(b), "txd data");
    endtask

    task automatic test_loopback();
        logic [uart_reg_pkg::reg_w-1:0] r;
        logic [uart_reg_pkg::reg_w-1:0] exp_stat;
        loop_en = 1'b1;
        exp_q.delete();
        write_random(10, 1'b0);
        poll_stat(uart_reg_pkg::stat_rx_lo, 10, "rx count");
        // TX side drained, ten bytes waiting, no errors
        exp_stat = (uart_reg_pkg::reg_w'(10) << uart_reg_pkg::stat_rx_lo) |
                   (uart_reg_pkg::reg_w'(1) << uart_reg_pkg::stat_rxv);
        bus_read(uart_reg_pkg::reg_stat, r);
        check_reg(r, exp_stat, "reg_stat");
        read_expect(10);
    endtask

    task automatic test_backpressure();
        logic [uart_reg_pkg::reg_w-1:0] r;
        // slow line so the TX FIFO fills
        set_baud(20);
        stall_seen = 1'b0;
        write_random(uart_line_pkg::tx_siz + 3, 1'b1);
        check_bit(stall_seen, 1'b1, "bus_rdy low seen");
        // last write went in after a stall, FIFO full again
        bus_read(uart_reg_pkg::reg_stat, r);
        check_reg(uart_reg_pkg::reg_w'(r[uart_reg_pkg::stat_tx_lo +: uart_line_pkg::cnt_w]),
                  uart_reg_pkg::reg_w'(uart_line_pkg::tx_siz), "stat tx count");
        poll_stat(uart_reg_pkg::stat_rx_lo, uart_line_pkg::tx_siz + 3, "rx count");
        read_expect(uart_line_pkg::tx_siz + 3);
        bus_read(uart_reg_pkg::reg_stat, r);
        check_reg(r, '0, "reg_stat");
    endtask

    task automatic test_overrun();
        logic [uart_reg_pkg::reg_w-1:0] r;
        set_baud(4);
        ovr_seen = 1'b0;
        write_random(uart_line_pkg::rx_siz + 2, 1'b1);
        poll_stat(uart_reg_pkg::stat_tx_lo, 0, "tx count");
        // last frame still on the line, 10 bits plus sync margin
        wait_cycles(12 * div_now + 10);
        poll_stat(uart_reg_pkg::stat_rx_lo, uart_line_pkg::rx_siz, "rx count");
        check_bit(ovr_seen, 1'b1, "stat_ovr");
        read_expect(uart_line_pkg::rx_siz);
        // last two were dropped
        exp_q.delete();
        bus_read(uart_reg_pkg::reg_stat, r);
        check_reg(r, '0, "reg_stat");
    endtask

    task automatic test_frame_error();
        logic [uart_reg_pkg::reg_w-1:0]  r;
        logic [uart_line_pkg::dat_w-1:0] bad;
        logic [uart_line_pkg::dat_w-1:0] good;
        loop_en   = 1'b0;
        line_rxd  = 1'b1;
        ferr_seen = 1'b0;
        wait_cycles(4);
        rand_byte(bad);
        rand_byte(good);
        line_send_frame(bad, 1'b0);
        // idle high so the next start edge is seen
        wait_cycles(2 * div_now);
        line_send_frame(good, 1'b1);
        poll_stat(uart_reg_pkg::stat_rx_lo, 1, "rx count");
        check_bit(ferr_seen, 1'b1, "stat_ferr");
        bus_read(uart_reg_pkg::reg_data, r);
        check_reg(r, uart_reg_pkg::reg_w'(good), "reg_data");
        bus_read(uart_reg_pkg::reg_stat, r);
        check_reg(r, '0, "reg_stat");
    endtask

    ////////////////////////////////////////
    // sequence
    ////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        bus_vld    = 1'b0;
        bus_wen    = 1'b0;
        bus_adr    = '0;
        bus_wdt    = '0;
        loop_en    = 1'b0;
        line_rxd   = 1'b1;
        div_now    = uart_line_pkg::div_rst;
        lfsr_q     = 32'h876c_a992;
        stall_seen = 1'b0;
        ovr_seen   = 1'b0;
        ferr_seen  = 1'b0;
        // reset for 4 cycles
        repeat (4) @(posedge clk);
        #drv_dly;
        rst = 1'b0;
        wait_cycles(1);

        test_reset();
        test_framing();
        test_loopback();
        test_backpressure();
        test_overrun();
        test_frame_error();

        $display("** PASS **");
        $finish;
    end

endmodule: uart_ctl_tb

//--- verilog/uart_ctl.sv
// UART controller top level
// register stage, TX and RX FIFOs, serializer and deserializer

module uart_ctl (
    input  logic                           clk,
    input  logic                           rst,
    // register bus
    input  logic                           bus_vld,
    input  logic                           bus_wen,
    input  logic [uart_reg_pkg::adr_w-1:0] bus_adr,
    input  logic [uart_reg_pkg::reg_w-1:0] bus_wdt,
    output logic                           bus_rdy,
    output logic                           rsp_vld,
    output logic [uart_reg_pkg::reg_w-1:0] rsp_rdt,
    // serial line
    output logic                           txd,
    input  logic                           rxd
);

    // transmit path
    logic                            tx_vld;
    logic                            tx_rdy;
    logic [uart_line_pkg::dat_w-1:0] tx_dat;
    logic [uart_line_pkg::cnt_w-1:0] tx_cnt;
    logic                            ser_vld;
    logic                            ser_rdy;
    logic [uart_line_pkg::dat_w-1:0] ser_dat;

    // receive path
    logic                            des_vld;
    logic                            des_rdy;
    logic [uart_line_pkg::dat_w-1:0] des_dat;
    logic                            rx_vld;
    logic                            rx_rdy;
    logic [uart_line_pkg::dat_w-1:0] rx_dat;
    logic [uart_line_pkg::cnt_w-1:0] rx_cnt;

    // control
    logic                            ovr_pls;
    logic                            ferr_pls;
    logic [uart_line_pkg::div_w-1:0] div;

    uart_regs uart_regs_inst (
        .clk, .rst,
        .bus_vld, .bus_wen, .bus_adr, .bus_wdt, .bus_rdy,
        .rsp_vld, .rsp_rdt,
        .tx_vld, .tx_dat, .tx_rdy,
        .rx_vld, .rx_dat, .rx_rdy,
        .tx_cnt, .rx_cnt,
        .ovr_pls, .ferr_pls,
        .div
    );

    uart_fifo #(
        .SIZ (uart_line_pkg::tx_siz),
        .DAT (uart_line_pkg::dat_w)
    ) tx_fifo (
        .clk, .rst,
        .sti_vld (tx_vld),  .sti_dat (tx_dat),  .sti_rdy (tx_rdy),
        .sto_vld (ser_vld), .sto_dat (ser_dat), .sto_rdy (ser_rdy),
        .cnt     (tx_cnt)
    );

    uart_ser uart_ser_inst (
        .clk, .rst, .div,
        .ser_vld, .ser_dat, .ser_rdy,
        .txd
    );

    uart_des uart_des_inst (
        .clk, .rst, .div, .rxd,
        .des_vld, .des_dat, .des_rdy,
        .ovr_pls, .ferr_pls
    );

    uart_fifo #(
        .SIZ (uart_line_pkg::rx_siz),
        .DAT (uart_line_pkg::dat_w)
    ) rx_fifo (
        .clk, .rst,
        .sti_vld (des_vld), .sti_dat (des_dat), .sti_rdy (des_rdy),
        .sto_vld (rx_vld),  .sto_dat (rx_dat),  .sto_rdy (rx_rdy),
        .cnt     (rx_cnt)
    );

endmodule: uart_ctl

//--- verilog/uart_regs.sv
// UART register bus stage
// maps bus accesses onto FIFO streams, holds baud divider and sticky error flags

module uart_regs (
    input  logic                            clk,
    input  logic                            rst,
    // register bus
    input  logic                            bus_vld,
    input  logic                            bus_wen,
    input  logic [uart_reg_pkg::adr_w-1:0]  bus_adr,
    input  logic [uart_reg_pkg::reg_w-1:0]  bus_wdt,
    output logic                            bus_rdy,
    // read response
    output logic                            rsp_vld,
    output logic [uart_reg_pkg::reg_w-1:0]  rsp_rdt,
    // TX FIFO write stream
    output logic                            tx_vld,
    output logic [uart_line_pkg::dat_w-1:0] tx_dat,
    input  logic                            tx_rdy,
    // RX FIFO read stream
    input  logic                            rx_vld,
    input  logic [uart_line_pkg::dat_w-1:0] rx_dat,
    output logic                            rx_rdy,
    // FIFO levels
    input  logic [uart_line_pkg::cnt_w-1:0] tx_cnt,
    input  logic [uart_line_pkg::cnt_w-1:0] rx_cnt,
    // error pulses from the deserializer
    input  logic                            ovr_pls,
    input  logic                            ferr_pls,
    // baud divider
    output logic [uart_line_pkg::div_w-1:0] div
);

    uart_reg_pkg::reg_adr_t         adr;
    logic                           trn;
    logic                           dat_sel;
    logic                           ovr;
    logic                           ferr;
    logic [uart_reg_pkg::reg_w-1:0] stat;
    logic [uart_reg_pkg::reg_w-1:0] rdt;

    assign adr     = uart_reg_pkg::reg_adr_t'(bus_adr);
    assign dat_sel = bus_vld & (adr == uart_reg_pkg::reg_data);

    ////////////////////////////////////////
    // handshake and streams
    ////////////////////////////////////////

    // only a data write into a full TX FIFO stalls
    assign bus_rdy = ~(bus_wen & (adr == uart_reg_pkg::reg_data) & ~tx_rdy);
    assign trn     = bus_vld & bus_rdy;

    assign tx_vld = dat_sel & bus_wen;
    assign tx_dat = bus_wdt[uart_line_pkg::dat_w-1:0];
    // pop in the accept cycle, no effect when empty
    assign rx_rdy = dat_sel & ~bus_wen;

    // status word
    always_comb begin
        stat = '0;
        stat[uart_reg_pkg::stat_tx_lo +: uart_line_pkg::cnt_w] = tx_cnt;
        stat[uart_reg_pkg::stat_rx_lo +: uart_line_pkg::cnt_w] = rx_cnt;
        stat[uart_reg_pkg::stat_ovr]  = ovr;
        stat[uart_reg_pkg::stat_ferr] = ferr;
        stat[uart_reg_pkg::stat_rxv]  = rx_vld;
    end

    // read mux, empty RX FIFO reads as zero
    always_comb begin
        case (adr)
            uart_reg_pkg::reg_data: rdt = rx_vld ? uart_reg_pkg::reg_w'(rx_dat) : '0;
            uart_reg_pkg::reg_stat: rdt = stat;
            uart_reg_pkg::reg_baud: rdt = uart_reg_pkg::reg_w'(div);
            default:                rdt = '0;
        endcase
    end

    ////////////////////////////////////////
    // registers and response
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (trn && !bus_wen) begin
            rsp_rdt <= rdt;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rsp_vld <= 1'b0;
            div     <= uart_line_pkg::div_rst;
            ovr     <= 1'b0;
            ferr    <= 1'b0;
        end else begin
            rsp_vld <= trn & ~bus_wen;
            if (trn && bus_wen && adr == uart_reg_pkg::reg_baud) begin
                div <= bus_wdt[uart_line_pkg::div_w-1:0];
            end
            // a status read hands the flags over, new pulses still land
            if (trn && !bus_wen && adr == uart_reg_pkg::reg_stat) begin
                ovr  <= ovr_pls;
                ferr <= ferr_pls;
            end else begin
                ovr  <= ovr | ovr_pls;
                ferr <= ferr | ferr_pls;
            end
        end
    end

endmodule: uart_regs

//--- verilog/uart_des.sv
// UART receive deserializer
// synchronizes rxd, samples 8N1 frames mid-bit, reports overrun and frame errors

module uart_des (
    input  logic                            clk,
    input  logic                            rst,
    // bit period in clock cycles
    input  logic [uart_line_pkg::div_w-1:0] div,
    // serial line, asynchronous
    input  logic                            rxd,
    // byte stream, no back-pressure
    output logic                            des_vld,
    output logic [uart_line_pkg::dat_w-1:0] des_dat,
    input  logic                            des_rdy,
    // error pulses
    output logic                            ovr_pls,
    output logic                            ferr_pls
);

    uart_line_pkg::des_state_t       state;
    logic                            rxd_s1;
    logic                            rxd_s2;
    logic                            rxd_d;
    logic                            fall;
    logic [uart_line_pkg::div_w-1:0] div_q;
    logic [uart_line_pkg::div_w-1:0] per;
    logic [2:0]                      idx;
    logic                            smp;

    ////////////////////////////////////////
    // synchronizer and edge detect
    ////////////////////////////////////////

    // idle line is high
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
            rxd_d  <= 1'b1;
        end else begin
            rxd_s1 <= rxd;
            rxd_s2 <= rxd_s1;
            rxd_d  <= rxd_s2;
        end
    end

    assign fall = rxd_d & ~rxd_s2;
    // sample point, counter runs out mid-bit
    assign smp  = (per == '0);

    // divider held for the whole frame
    always_ff @(posedge clk) begin
        if (state == uart_line_pkg::des_idle && fall) begin
            div_q <= div;
        end
    end

    // data shifted in LSB first, MSB side entry
    always_ff @(posedge clk) begin
        if (state == uart_line_pkg::des_data && smp) begin
            des_dat <= {rxd_s2, des_dat[uart_line_pkg::dat_w-1:1]};
        end
    end

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= uart_line_pkg::des_idle;
            per      <= '0;
            idx      <= '0;
            des_vld  <= 1'b0;
            ferr_pls <= 1'b0;
        end else begin
            des_vld  <= 1'b0;
            ferr_pls <= 1'b0;
            per      <= smp ? div_q - 1'b1 : per - 1'b1;
            case (state)
                uart_line_pkg::des_idle: begin
                    if (fall) begin
                        // half period offset to mid start bit
                        state <= uart_line_pkg::des_start;
                        per   <= (div >> 1) - 1'b1;
                    end
                end
                uart_line_pkg::des_start: begin
                    if (smp) begin
                        // glitch, start bit gone high again
                        state <= rxd_s2 ? uart_line_pkg::des_idle : uart_line_pkg::des_data;
                        idx   <= '0;
                    end
                end
                uart_line_pkg::des_data: begin
                    if (smp) begin
                        idx <= idx + 1'b1;
                        if (idx == 3'd7) begin
                            state <= uart_line_pkg::des_stop;
                        end
                    end
                end
                uart_line_pkg::des_stop: begin
                    if (smp) begin
                        state    <= uart_line_pkg::des_idle;
                        des_vld  <= rxd_s2;
                        ferr_pls <= ~rxd_s2;
                    end
                end
            endcase
        end
    end

    // byte lost if the RX FIFO cannot take it
    assign ovr_pls = des_vld & ~des_rdy;

endmodule: uart_des

//--- verilog/uart_ser.sv
// UART transmit serializer
// shifts out one 8N1 frame per accepted byte, LSB first

module uart_ser (
    input  logic                            clk,
    input  logic                            rst,
    // bit period in clock cycles
    input  logic [uart_line_pkg::div_w-1:0] div,
    // byte stream
    input  logic                            ser_vld,
    input  logic [uart_line_pkg::dat_w-1:0] ser_dat,
    output logic                            ser_rdy,
    // serial line
    output logic                            txd
);

    uart_line_pkg::ser_state_t       state;
    logic [uart_line_pkg::div_w-1:0] div_q;
    logic [uart_line_pkg::div_w-1:0] per;
    logic [2:0]                      idx;
    logic [uart_line_pkg::dat_w-1:0] sh;
    logic                            trn;
    logic                            per_end;

    assign ser_rdy = (state == uart_line_pkg::ser_idle);
    assign trn     = ser_vld & ser_rdy;
    // last cycle of a bit period
    assign per_end = (per == '0);

    // byte and divider latched at acceptance, data shifted per bit
    always_ff @(posedge clk) begin
        if (trn) begin
            sh    <= ser_dat;
            div_q <= div;
        end else if (per_end && (state == uart_line_pkg::ser_start ||
                                 state == uart_line_pkg::ser_data)) begin
            sh <= sh >> 1;
        end
    end

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= uart_line_pkg::ser_idle;
            per   <= '0;
            idx   <= '0;
            txd   <= 1'b1;
        end else begin
            per <= per_end ? div_q - 1'b1 : per - 1'b1;
            case (state)
                uart_line_pkg::ser_idle: begin
                    if (trn) begin
                        // start bit from the next cycle
                        state <= uart_line_pkg::ser_start;
                        per   <= div - 1'b1;
                        txd   <= 1'b0;
                    end
                end
                uart_line_pkg::ser_start: begin
                    if (per_end) begin
                        state <= uart_line_pkg::ser_data;
                        idx   <= '0;
                        txd   <= sh[0];
                    end
                end
                uart_line_pkg::ser_data: begin
                    if (per_end) begin
                        idx <= idx + 1'b1;
                        if (idx == 3'd7) begin
                            state <= uart_line_pkg::ser_stop;
                            txd   <= 1'b1;
                        end else begin
                            txd <= sh[0];
                        end
                    end
                end
                uart_line_pkg::ser_stop: begin
                    // line stays high into idle
                    if (per_end) begin
                        state <= uart_line_pkg::ser_idle;
                    end
                end
            endcase
        end
    end

endmodule: uart_ser

//--- verilog/uart_fifo.sv
// UART stream FIFO
// circular addresses, distributed memory with asynchronous read, occupancy count

module uart_fifo #(
    parameter int unsigned SIZ = 16,
    parameter int unsigned DAT = 8
)(
    input  logic                            clk,
    input  logic                            rst,
    // stream input
    input  logic                            sti_vld,
    input  logic [DAT-1:0]                  sti_dat,
    output logic                            sti_rdy,
    // stream output
    output logic                            sto_vld,
    output logic [DAT-1:0]                  sto_dat,
    input  logic                            sto_rdy,
    // occupancy
    output logic [uart_line_pkg::cnt_w-1:0] cnt
);

    // address width from depth
    localparam int unsigned adr_w = $clog2(SIZ);

    logic             sti_trn;
    logic             sto_trn;
    logic [adr_w-1:0] sti_adr;
    logic [adr_w-1:0] sto_adr;
    logic [DAT-1:0]   mem [0:SIZ-1];

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    assign sti_trn = sti_vld & sti_rdy;

    // write address, wraps at SIZ
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sti_adr <= '0;
        end else if (sti_trn) begin
            sti_adr <= (sti_adr == adr_w'(SIZ-1)) ? '0 : sti_adr + 1'b1;
        end
    end

    // memory write
    always_ff @(posedge clk) begin
        if (sti_trn) begin
            mem[sti_adr] <= sti_dat;
        end
    end

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////

    assign sto_trn = sto_vld & sto_rdy;

    // asynchronous read, head entry always on the output
    assign sto_dat = mem[sto_adr];

    // read address
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sto_adr <= '0;
        end else if (sto_trn) begin
            sto_adr <= (sto_adr == adr_w'(SIZ-1)) ? '0 : sto_adr + 1'b1;
        end
    end

    // occupancy, push and pop may happen together
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + uart_line_pkg::cnt_w'(sti_trn) - uart_line_pkg::cnt_w'(sto_trn);
        end
    end

    // not full / not empty
    assign sti_rdy = (cnt != uart_line_pkg::cnt_w'(SIZ));
    assign sto_vld = (cnt != '0);

endmodule: uart_fifo

//--- verilog/uart_reg_pkg.sv
// UART register bus definitions
// address map and status register layout

package uart_reg_pkg;

    // bus widths
    localparam int unsigned adr_w = 2;
    localparam int unsigned reg_w = 16;

    // register address map
    typedef enum logic [1:0] {
        // write pushes TX FIFO, read pops RX FIFO
        reg_data = 2'd0,
        // status, read only
        reg_stat = 2'd1,
        // baud divider
        reg_baud = 2'd2
    } reg_adr_t;

    ////////////////////////////////////////
    // status bit positions
    ////////////////////////////////////////

    // TX FIFO count, bits 5..0
    localparam int unsigned stat_tx_lo = 0;
    // RX FIFO count, bits 11..6
    localparam int unsigned stat_rx_lo = 6;
    // sticky flags
    localparam int unsigned stat_ovr  = 12;
    localparam int unsigned stat_ferr = 13;
    // RX FIFO not empty
    localparam int unsigned stat_rxv  = 14;

endpackage: uart_reg_pkg

//--- verilog/uart_line_pkg.sv
// UART serial line definitions
// character and divider widths, FIFO depths, line FSM states

package uart_line_pkg;

    // character width, 8N1 frames only
    localparam int unsigned dat_w = 8;

    // baud divider, clock cycles per bit
    localparam int unsigned div_w = 16;
    localparam logic [div_w-1:0] div_rst = 16'd10;

    // FIFO depths
    localparam int unsigned tx_siz = 16;
    localparam int unsigned rx_siz = 32;

    // occupancy count, holds 0..rx_siz
    localparam int unsigned cnt_w = 6;

    // transmit serializer states
    typedef enum logic [1:0] {
        ser_idle  = 2'd0,
        ser_start = 2'd1,
        ser_data  = 2'd2,
        ser_stop  = 2'd3
    } ser_state_t;

    // receive deserializer states
    typedef enum logic [1:0] {
        des_idle  = 2'd0,
        des_start = 2'd1,
        des_data  = 2'd2,
        des_stop  = 2'd3
    } des_state_t;

endpackage: uart_line_pkg
